// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/sdram_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module sdram_model
  import sdram_pkg::*;
(
  input  wire                ddr_clk,
  input  wire                rst_n,
  input  wire                cs_n,
  input  wire                ras_n,
  input  wire                cas_n,
  input  wire                we_n,
  input  bank_t              ba,
  input  wire  [`ROW_W-1:0]  sd_addr,
  input  wire  [1:0]         dm,
  inout  wire  [`DATA_W-1:0] dq
);

  localparam int KEY_W = `BANK_W + `ROW_W + `COL_W;

  logic [`DATA_W-1:0] mem [logic [KEY_W-1:0]];   // Sparse storage where unwritten words read 0
  row_t               open_row [2**`BANK_W];
  sdram_cmd_e         cmd;
  logic [KEY_W-1:0]   key;
  logic [`DATA_W-1:0] rd_word;
  logic [`DATA_W-1:0] old_word;
  logic [`CAS_LAT-1:0] rd_pipe;

  function automatic logic [`DATA_W-1:0] stored_word(input logic [KEY_W-1:0] k);
    return mem.exists(k) ? mem[k] : '0;
  endfunction

  assign cmd = cs_n ? CMD_NOP : sdram_cmd_e'({ras_n, cas_n, we_n});
  assign key = {ba, open_row[ba], col_t'(sd_addr)};

  // Read data appears on the bus CAS_LAT cycles after RD
  assign dq = rd_pipe[`CAS_LAT-1] ? rd_word : 'z;

  always_ff @(posedge ddr_clk or negedge rst_n)
    if (!rst_n)
      rd_pipe <= '0;
    else
      rd_pipe <= {rd_pipe[`CAS_LAT-2:0], cmd == CMD_RD};

  always @(posedge ddr_clk)
  begin
    old_word = stored_word(key);
    case (cmd)
      CMD_ACT:
        open_row[ba] <= sd_addr;
      CMD_RD:
        rd_word <= old_word;
      CMD_WR:
      begin
        // dm high keeps the stored byte
        mem[key] = {dm[1] ? old_word[15:8] : dq[15:8],
                    dm[0] ? old_word[7:0]  : dq[7:0]};
      end
      default:
      begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: dv/tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module tb_mem_subsys
  import sdram_pkg::*;
;

  localparam int CLK_PERIOD   = 100;
  localparam int N_TESTS      = 18;
  localparam int WATCHDOG_CYC = (N_TESTS + 1) * 20;

  typedef enum logic [2:0] {OP_MW, OP_MR, OP_IW, OP_IR, OP_OVF} op_e;

  typedef struct packed {
    op_e                op;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
    logic               byte_m;
    logic               rnd;      // Random write data or a read predicted by ref_mem
    logic               hold;     // Wait for all responses after this entry
    logic [`DATA_W-1:0] exp;
  } test_t;

  typedef struct packed {
    logic               chk;
    logic [`DATA_W-1:0] data;
  } resp_t;

  logic               ddr_clk;
  logic               rst_n;
  logic               mem_op;
  logic               m_io;
  logic [`ADDR_W-1:0] addr;
  logic [`DATA_W-1:0] wr_data;
  logic               we;
  logic               byte_m;
  logic [`DATA_W-1:0] rd_data;
  logic               ready;
  logic               req_overflow;
  logic               cs_n;
  logic               ras_n;
  logic               cas_n;
  logic               we_n;
  bank_t              ba;
  logic [`ROW_W-1:0]  sd_addr;
  logic [1:0]         dm;
  wire  [`DATA_W-1:0] dq;
  logic               dq_dir;

  test_t              tests [N_TESTS];
  resp_t              resp_q [$];
  resp_t              mon_r;
  logic               skip_resp;
  logic [`DATA_W-1:0] ref_mem [logic [`ADDR_W-1:0]];

  mem_subsys i_dut (
    .ddr_clk, .rst_n, .mem_op, .m_io, .addr, .wr_data, .we, .byte_m,
    .rd_data, .ready, .req_overflow,
    .cs_n, .ras_n, .cas_n, .we_n, .ba, .sd_addr, .dm, .dq, .dq_dir
  );

  sdram_model u_sdram (
    .ddr_clk, .rst_n, .cs_n, .ras_n, .cas_n, .we_n, .ba, .sd_addr, .dm, .dq
  );

  initial
  begin
    ddr_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ddr_clk = ~ddr_clk;
  end

  initial
  begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Timeout after %0d cycles while waiting for the DUT", WATCHDOG_CYC);
    $display("TESTS FAILED");
    $fatal(1);
  end

  task automatic check_data(input string name, input logic [`DATA_W-1:0] got, exp);
    if (got !== exp)
    begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input bit got, exp);
    if (got != exp)
    begin
      $display("ERR %0t %s got %0b expected %0b", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [`DATA_W-1:0] ref_read(input logic [`ADDR_W-1:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : '0;
  endfunction

  task automatic ref_write(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
                           input logic byte_only);
    logic [`DATA_W-1:0] old;
    old = ref_read(a);
    ref_mem[a] = byte_only ? {old[15:8], d[7:0]} : d;
  endtask

  // Responses come back in request order
  always @(negedge ddr_clk)
    if (rst_n && !skip_resp && ready)
    begin
      if (resp_q.size() == 0)
      begin
        $display("Unexpected ready at %0t with no request outstanding", $time);
        $display("TESTS FAILED");
        $fatal(1);
      end
      else
      begin
        mon_r = resp_q.pop_front();
        if (mon_r.chk)
          check_data("rd_data", rd_data, mon_r.data);
      end
    end

  task automatic load_table();
    // op, addr, data, byte_m, rnd, hold, exp
    tests[0]  = '{OP_MW,  20'h01234, 16'hbeef, 1'b0, 1'b0, 1'b1, 16'h0000};
    tests[1]  = '{OP_MR,  20'h01234, 16'h0000, 1'b0, 1'b0, 1'b1, 16'hbeef};
    tests[2]  = '{OP_MW,  20'h01234, 16'h1255, 1'b1, 1'b0, 1'b1, 16'h0000};
    tests[3]  = '{OP_MR,  20'h01234, 16'h0000, 1'b0, 1'b0, 1'b1, 16'hbe55};
    tests[4]  = '{OP_MR,  20'h3a0c1, 16'h0000, 1'b0, 1'b0, 1'b1, 16'h0000};
    tests[5]  = '{OP_IW,  20'h000b7, 16'ha5c3, 1'b0, 1'b0, 1'b1, 16'h0000};
    tests[6]  = '{OP_IR,  20'h000b7, 16'h0000, 1'b0, 1'b0, 1'b1, 16'ha5c3};
    tests[7]  = '{OP_IW,  20'h000b7, 16'h777e, 1'b1, 1'b0, 1'b1, 16'h0000};
    tests[8]  = '{OP_IR,  20'h000b7, 16'h0000, 1'b0, 1'b0, 1'b1, 16'ha57e};
    tests[9]  = '{OP_IR,  20'h000b6, 16'h0000, 1'b0, 1'b0, 1'b1, 16'h0000};
    tests[10] = '{OP_MW,  20'h10000, 16'h0000, 1'b0, 1'b1, 1'b0, 16'h0000};
    tests[11] = '{OP_MW,  20'h2f0e7, 16'h0000, 1'b0, 1'b1, 1'b0, 16'h0000};
    tests[12] = '{OP_MR,  20'h10000, 16'h0000, 1'b0, 1'b1, 1'b1, 16'h0000};
    tests[13] = '{OP_MR,  20'h2f0e7, 16'h0000, 1'b0, 1'b1, 1'b1, 16'h0000};
    tests[14] = '{OP_MW,  20'h07ff0, 16'h0f0f, 1'b0, 1'b0, 1'b1, 16'h0000};
    tests[15] = '{OP_OVF, 20'h50000, 16'h0000, 1'b0, 1'b0, 1'b1, 16'h0000};
    tests[16] = '{OP_MR,  20'h01234, 16'h0000, 1'b0, 1'b0, 1'b1, 16'hbe55};
    tests[17] = '{OP_IR,  20'h000b7, 16'h0000, 1'b0, 1'b0, 1'b1, 16'h0000};
  endtask

  task automatic apply_reset();
    rst_n <= 1'b0;
    repeat (3) @(posedge ddr_clk);
    rst_n <= 1'b1;
    @(posedge ddr_clk);
  endtask

  task automatic run_entry(input test_t t);
    logic [`DATA_W-1:0] data;
    resp_t              r;
    data = t.rnd ? `DATA_W'($urandom) : t.data;
    @(posedge ddr_clk);
    mem_op  <= 1'b1;
    m_io    <= (t.op == OP_IW) || (t.op == OP_IR);
    we      <= (t.op == OP_MW) || (t.op == OP_IW);
    addr    <= t.addr;
    wr_data <= data;
    byte_m  <= t.byte_m;
    r.chk  = (t.op == OP_MR) || (t.op == OP_IR);
    r.data = (t.op == OP_MR && t.rnd) ? ref_read(t.addr) : t.exp;
    if (t.op == OP_MW)
      ref_write(t.addr, data, t.byte_m);
    resp_q.push_back(r);
  endtask

  task automatic wait_idle();
    while (resp_q.size() != 0)
      @(posedge ddr_clk);
  endtask

  // More strobes than FIFO slots while the sequencer is busy
  task automatic overflow_burst(input logic [`ADDR_W-1:0] base);
    skip_resp = 1'b1;
    for (int n = 0; n < `FIFO_DEPTH + 2; n++)
    begin
      @(posedge ddr_clk);
      mem_op  <= 1'b1;
      m_io    <= 1'b0;
      we      <= 1'b1;
      byte_m  <= 1'b0;
      addr    <= base + `ADDR_W'(n);
      wr_data <= `DATA_W'($urandom);
    end
    @(posedge ddr_clk);
    mem_op <= 1'b0;
    repeat (3) @(posedge ddr_clk);     // Last push lands a cycle after its strobe
    check_flag("req_overflow", req_overflow, 1'b1);
    apply_reset();
    resp_q.delete();
    skip_resp = 1'b0;
    check_flag("req_overflow", req_overflow, 1'b0);
  endtask

  initial
  begin
    rst_n     = 1'b0;
    mem_op    = 1'b0;
    m_io      = 1'b0;
    addr      = '0;
    wr_data   = '0;
    we        = 1'b0;
    byte_m    = 1'b0;
    skip_resp = 1'b0;
    void'($urandom(32'h6444));
    load_table();
    apply_reset();
    for (int i = 0; i < N_TESTS; i++)
    begin
      if (tests[i].op == OP_OVF)
        overflow_burst(tests[i].addr);
      else
      begin
        run_entry(tests[i]);
        if (tests[i].hold)
        begin
          @(posedge ddr_clk);
          mem_op <= 1'b0;
          wait_idle();
          check_flag("req_overflow", req_overflow, 1'b0);
          if (tests[i].op == OP_MR || tests[i].op == OP_MW)
            check_flag("dq_dir", dq_dir, tests[i].op == OP_MR);
        end
      end
    end
    repeat (2) @(posedge ddr_clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/cpu_bus_pkg.sv
src/sdram_pkg.sv
src/cpu_bus_port.sv
src/req_fifo.sv
src/sdram_sequencer.sv
src/mem_subsys.sv
dv/sdram_model.sv
dv/tb_mem_subsys.sv

// File: src/cpu_bus_pkg.sv
`default_nettype none

`include "mem_config.svh"

package cpu_bus_pkg;

  // I/O space uses the full CPU address
  typedef logic [`ADDR_W-1:0] io_addr_t;

  // One queued memory access of 38 bits
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wr_data;
    logic               we;
    logic               byte_m;    // Low byte only
  } cpu_req_t;

endpackage

`default_nettype wire

// File: src/cpu_bus_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module cpu_bus_port
  import cpu_bus_pkg::*;
(
  input  logic               ddr_clk,
  input  logic               rst_n,
  input  logic               mem_op,
  input  logic               m_io,
  input  logic               we,
  input  logic               byte_m,
  input  logic [`ADDR_W-1:0] addr,
  input  logic [`DATA_W-1:0] wr_data,
  output logic [`DATA_W-1:0] rd_data,
  output logic               ready,
  output logic               req_overflow,
  output logic               push_en,
  output cpu_req_t           push_data,
  input  logic               full,
  input  logic               mem_done,
  input  logic [`DATA_W-1:0] mem_rdata
);

  localparam io_addr_t IO_ADDR = `IO_REG_ADDR;

  logic [`DATA_W-1:0] io_reg;
  logic [`DATA_W-1:0] io_rdata;
  logic               io_ready;
  logic               io_hit;

  assign io_hit = (addr == IO_ADDR);

  // I/O register and response strobe
  always_ff @(posedge ddr_clk or negedge rst_n)
    if (!rst_n)
    begin
      io_reg   <= '0;
      io_ready <= 1'b0;
    end
    else
    begin
      io_ready <= mem_op & m_io;
      if (mem_op & m_io & we & io_hit)
        io_reg <= byte_m ? {io_reg[`DATA_W-1:8], wr_data[7:0]} : wr_data;
    end

  always_ff @(posedge ddr_clk)
    if (mem_op & m_io)
      io_rdata <= io_hit ? io_reg : '0;   // Unmapped I/O reads as zero

  // Memory requests go to the FIFO one cycle later
  always_ff @(posedge ddr_clk or negedge rst_n)
    if (!rst_n)
    begin
      push_en      <= 1'b0;
      req_overflow <= 1'b0;
    end
    else
    begin
      push_en <= mem_op & ~m_io;
      if (push_en & full)
        req_overflow <= 1'b1;              // Sticky until reset
    end

  always_ff @(posedge ddr_clk)
    if (mem_op & ~m_io)
      push_data <= '{addr: addr, wr_data: wr_data, we: we, byte_m: byte_m};

  // I/O only issued with no memory access in flight
  assign ready   = io_ready | mem_done;
  assign rd_data = io_ready ? io_rdata : mem_rdata;

endmodule

`default_nettype wire

// File: src/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// CPU bus
`define ADDR_W       20
`define DATA_W       16

// SDRAM address split into bank, row and column
`define BANK_W       2
`define ROW_W        13
`define COL_W        5

// Request queue
`define FIFO_DEPTH   4

// SDRAM timing in ddr_clk cycles
`define T_RCD        2    // Activate to read or write
`define CAS_LAT      2    // Read command to data

// Local I/O register
`define IO_REG_ADDR  20'hb7

`endif

// File: src/mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module mem_subsys
  import cpu_bus_pkg::*;
  import sdram_pkg::*;
(
  input  logic               ddr_clk,
  input  logic               rst_n,
  // CPU side
  input  logic               mem_op,
  input  logic               m_io,
  input  logic [`ADDR_W-1:0] addr,
  input  logic [`DATA_W-1:0] wr_data,
  input  logic               we,
  input  logic               byte_m,
  output logic [`DATA_W-1:0] rd_data,
  output logic               ready,
  output logic               req_overflow,
  // SDRAM pins
  output logic               cs_n,
  output logic               ras_n,
  output logic               cas_n,
  output logic               we_n,
  output bank_t              ba,
  output logic [`ROW_W-1:0]  sd_addr,
  output logic [1:0]         dm,
  inout  wire  [`DATA_W-1:0] dq,
  output logic               dq_dir
);

  logic               push_en;
  cpu_req_t           push_data;
  logic               full;
  logic               empty;
  cpu_req_t           head_data;
  logic               pop_en;
  logic               mem_done;
  logic [`DATA_W-1:0] mem_rdata;

  cpu_bus_port u_port (
    .ddr_clk, .rst_n, .mem_op, .m_io, .we, .byte_m, .addr, .wr_data,
    .rd_data, .ready, .req_overflow, .push_en, .push_data, .full,
    .mem_done, .mem_rdata
  );

  req_fifo #(.payload_t(cpu_req_t)) u_fifo (
    .ddr_clk, .rst_n, .push_en, .push_data, .pop_en, .head_data, .empty, .full
  );

  sdram_sequencer u_seq (
    .ddr_clk, .rst_n, .empty, .head_data, .pop_en,
    .cs_n, .ras_n, .cas_n, .we_n, .ba, .sd_addr, .dm, .dq, .dq_dir,
    .mem_done, .mem_rdata
  );

endmodule

`default_nettype wire

// File: src/req_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module req_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     ddr_clk,
  input  logic     rst_n,
  input  logic     push_en,
  input  payload_t push_data,
  input  logic     pop_en,
  output payload_t head_data,
  output logic     empty,
  output logic     full
);

  localparam int DEPTH = `FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign empty     = (count == '0);
  assign full      = (count == FULL_CNT);
  assign do_pop    = pop_en & ~empty;
  assign do_push   = push_en & (~full | do_pop);   // Full but popping still accepts
  assign head_data = mem[rd_ptr];

  always_ff @(posedge ddr_clk)
    if (do_push)
      mem[wr_ptr] <= push_data;

  always_ff @(posedge ddr_clk or negedge rst_n)
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end

endmodule

`default_nettype wire

// File: src/sdram_pkg.sv
`default_nettype none

`include "mem_config.svh"

package sdram_pkg;

  // {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    CMD_NOP = 3'b111,
    CMD_ACT = 3'b011,
    CMD_RD  = 3'b101,
    CMD_WR  = 3'b100,
    CMD_PRE = 3'b010
  } sdram_cmd_e;

  typedef logic [`ROW_W-1:0]  row_t;
  typedef logic [`COL_W-1:0]  col_t;
  typedef logic [`BANK_W-1:0] bank_t;

endpackage

`default_nettype wire

// File: src/sdram_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module sdram_sequencer
  import cpu_bus_pkg::*;
  import sdram_pkg::*;
(
  input  logic               ddr_clk,
  input  logic               rst_n,
  input  logic               empty,
  input  cpu_req_t           head_data,
  output logic               pop_en,
  output logic               cs_n,
  output logic               ras_n,
  output logic               cas_n,
  output logic               we_n,
  output bank_t              ba,
  output logic [`ROW_W-1:0]  sd_addr,
  output logic [1:0]         dm,
  inout  wire  [`DATA_W-1:0] dq,
  output logic               dq_dir,
  output logic               mem_done,
  output logic [`DATA_W-1:0] mem_rdata
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ACT,     // ACT on the pins
    S_WAIT,    // Counting out tRCD
    S_ACC,     // RD or WR on the pins
    S_CAS,     // Waiting for read data
    S_PRE      // PRE on the pins with mem_done high
  } state_e;

  state_e     state;
  sdram_cmd_e cmd_q;
  logic [2:0] cnt;
  logic       dq_oe;
  cpu_req_t   req_q;
  col_t       col_q;
  bank_t      head_bank;
  row_t       head_row;
  col_t       head_col;

  assign {head_bank, head_row, head_col} = head_data.addr;

  assign pop_en = (state == S_IDLE) & ~empty;

  assign {ras_n, cas_n, we_n} = cmd_q;
  assign cs_n = (cmd_q == CMD_NOP);     // Deselect while idle

  assign dq = dq_oe ? req_q.wr_data : 'z;
  assign dm = {dq_oe & req_q.byte_m, 1'b0};   // Byte write keeps upper byte

  always_ff @(posedge ddr_clk or negedge rst_n)
    if (!rst_n)
    begin
      state    <= S_IDLE;
      cmd_q    <= CMD_NOP;
      cnt      <= '0;
      dq_oe    <= 1'b0;
      mem_done <= 1'b0;
      ba       <= '0;
      sd_addr  <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (!empty)
          begin
            cmd_q   <= CMD_ACT;
            ba      <= head_bank;
            sd_addr <= head_row;
            state   <= S_ACT;
          end
        S_ACT:
        begin
          cmd_q <= CMD_NOP;
          cnt   <= 3'(`T_RCD - 2);
          state <= S_WAIT;
        end
        S_WAIT:
          if (cnt == '0)
          begin
            cmd_q   <= req_q.we ? CMD_WR : CMD_RD;
            sd_addr <= `ROW_W'(col_q);
            dq_oe   <= req_q.we;
            state   <= S_ACC;
          end
          else
            cnt <= cnt - 1'b1;
        S_ACC:
        begin
          dq_oe <= 1'b0;
          if (req_q.we)
          begin
            cmd_q    <= CMD_PRE;
            sd_addr  <= '0;
            mem_done <= 1'b1;
            state    <= S_PRE;
          end
          else
          begin
            cmd_q <= CMD_NOP;
            cnt   <= 3'(`CAS_LAT - 1);
            state <= S_CAS;
          end
        end
        S_CAS:
          if (cnt == '0)
          begin
            cmd_q    <= CMD_PRE;   // Closed page
            sd_addr  <= '0;
            mem_done <= 1'b1;
            state    <= S_PRE;
          end
          else
            cnt <= cnt - 1'b1;
        S_PRE:
        begin
          cmd_q    <= CMD_NOP;
          mem_done <= 1'b0;
          state    <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end

  always_ff @(posedge ddr_clk)
  begin
    if (pop_en)
    begin
      req_q <= head_data;
      col_q <= head_col;
    end
    if ((state == S_CAS) && (cnt == '0))
      mem_rdata <= dq;               // Sample CAS_LAT after RD
  end

  // Bus direction follows the last issued RD or WR
  always_ff @(posedge ddr_clk or negedge rst_n)
    if (!rst_n)
      dq_dir <= 1'b0;
    else if (cmd_q == CMD_RD)
      dq_dir <= 1'b1;
    else if (cmd_q == CMD_WR)
      dq_dir <= 1'b0;

endmodule

`default_nettype wire
